// ==== logic/oven_defs.svh ====
`ifndef OVEN_DEFS_SVH
`define OVEN_DEFS_SVH

// Display and keypad sizes
`define OVEN_DIGITS 4
`define KEY_COUNT 10
`define RECIPE_COUNT 4

// Time-of-day clock limits
`define SECONDS_PER_MINUTE 60
`define HOUR_LIMIT 23

// Recipe n (from 0) cooks for n plus this many minutes
`define RECIPE_MINUTES_BASE 1

// Key beep length in clock cycles
`define BEEP_CYCLES 4

// Done phase length in second ticks
`define DONE_SECONDS 3

`endif

// ==== logic/ovenPkg.sv ====
package ovenPkg;

    // One decimal display digit
    typedef logic [3:0] bcdDigit;

    // Controller phase
    // Entry accepts digits, ready holds a preset or a paused time
    typedef enum logic [2:0]
    {
        stIdle    = 3'd0,
        stEntry   = 3'd1,
        stReady   = 3'd2,
        stCooking = 3'd3,
        stDone    = 3'd4
    } ovenState;

endpackage

// ==== logic/keyInput.sv ====
`timescale 1ns/1ps
`include "oven_defs.svh"

module keyInput
(
    input  logic                        r,
    input  logic                        est2,
    input  logic [`KEY_COUNT-1:0]       numKey,
    input  logic                        startKey,
    input  logic                        cancelKey,
    input  logic [`RECIPE_COUNT-1:0]    recipeKey,
    output logic                        digitPress,
    output ovenPkg::bcdDigit            digitValue,
    output logic                        startPress,
    output logic                        cancelPress,
    output logic                        recipePress,
    output logic [1:0]                  recipeIndex
);

    logic [`KEY_COUNT-1:0]    numLast;
    logic [`RECIPE_COUNT-1:0] recipeLast;
    logic                     startLast;
    logic                     cancelLast;
    logic [`KEY_COUNT-1:0]    numRise;
    logic [`RECIPE_COUNT-1:0] recipeRise;
    ovenPkg::bcdDigit         digitCode;
    logic [1:0]               recipeCode;

    assign numRise    = numKey & ~numLast;
    assign recipeRise = recipeKey & ~recipeLast;

    // Scan from the top down so the lowest rising key is the one kept
    always_comb
    begin
        digitCode  = '0;
        recipeCode = '0;
        for (int i = `KEY_COUNT - 1; i >= 0; i--)
        begin
            if (numRise[i])
                digitCode = 4'(i);
        end
        for (int j = `RECIPE_COUNT - 1; j >= 0; j--)
        begin
            if (recipeRise[j])
                recipeCode = 2'(j);
        end
    end

    always_ff @(posedge r or posedge est2)
    begin
        if (est2)
        begin
            numLast     <= '0;
            recipeLast  <= '0;
            startLast   <= 1'b0;
            cancelLast  <= 1'b0;
            digitPress  <= 1'b0;
            startPress  <= 1'b0;
            cancelPress <= 1'b0;
            recipePress <= 1'b0;
        end
        else
        begin
            numLast     <= numKey;
            recipeLast  <= recipeKey;
            startLast   <= startKey;
            cancelLast  <= cancelKey;
            digitPress  <= |numRise;
            startPress  <= startKey & ~startLast;
            cancelPress <= cancelKey & ~cancelLast;
            recipePress <= |recipeRise;
        end
    end

    // Key codes are registered to line up with their strobes
    always_ff @(posedge r)
    begin
        digitValue  <= digitCode;
        recipeIndex <= recipeCode;
    end

endmodule

// ==== logic/ovenCtrl.sv ====
`timescale 1ns/1ps
`include "oven_defs.svh"

module ovenCtrl
(
    input  logic                r,
    input  logic                est2,
    input  logic                digitPress,
    input  ovenPkg::bcdDigit    digitValue,
    input  logic                startPress,
    input  logic                cancelPress,
    input  logic                recipePress,
    input  logic [1:0]          recipeIndex,
    input  logic                door,
    input  logic                secTick,
    input  logic                timeZero,
    output ovenPkg::ovenState   state,
    output logic                shiftDigit,
    output ovenPkg::bcdDigit    newDigit,
    output logic                loadRecipe,
    output logic [1:0]          recipeSel,
    output logic                clearTime,
    output logic                countDown,
    output logic                motor,
    output logic                heater,
    output logic                light,
    output logic                buzzer
);

    ovenPkg::ovenState stateNext;
    logic              shiftNext;
    logic              loadNext;
    logic              clearNext;
    logic              countNext;
    logic              keyAccepted;
    logic              startOk;
    logic [3:0]        doneCount;
    logic [2:0]        beepCount;

    // Start needs a closed door and something left to cook
    assign startOk = startPress & ~door & ~timeZero;

    always_comb
    begin
        stateNext   = state;
        shiftNext   = 1'b0;
        loadNext    = 1'b0;
        clearNext   = 1'b0;
        keyAccepted = 1'b0;
        case (state)
            ovenPkg::stIdle:
            begin
                if (digitPress)
                begin
                    // First digit replaces whatever time was left behind
                    clearNext   = 1'b1;
                    shiftNext   = 1'b1;
                    keyAccepted = 1'b1;
                    stateNext   = ovenPkg::stEntry;
                end
                else if (recipePress)
                begin
                    loadNext    = 1'b1;
                    keyAccepted = 1'b1;
                    stateNext   = ovenPkg::stReady;
                end
            end
            ovenPkg::stEntry, ovenPkg::stReady:
            begin
                if (cancelPress)
                begin
                    clearNext   = 1'b1;
                    keyAccepted = 1'b1;
                    stateNext   = ovenPkg::stIdle;
                end
                else if (startOk)
                begin
                    keyAccepted = 1'b1;
                    stateNext   = ovenPkg::stCooking;
                end
                else if (digitPress && state == ovenPkg::stEntry)
                begin
                    shiftNext   = 1'b1;
                    keyAccepted = 1'b1;
                end
            end
            ovenPkg::stCooking:
            begin
                // Pausing keeps the remaining time in the timer
                if (cancelPress || door)
                begin
                    keyAccepted = cancelPress;
                    stateNext   = ovenPkg::stReady;
                end
                else if (timeZero)
                    stateNext = ovenPkg::stDone;
            end
            ovenPkg::stDone:
            begin
                if (secTick && doneCount == 4'(`DONE_SECONDS - 1))
                begin
                    clearNext = 1'b1;
                    stateNext = ovenPkg::stIdle;
                end
            end
            default:
                stateNext = ovenPkg::stIdle;
        endcase
    end

    // Only count ticks that land while the oven stays in cooking
    assign countNext = secTick & (state == ovenPkg::stCooking) &
                       (stateNext == ovenPkg::stCooking);

    always_ff @(posedge r or posedge est2)
    begin
        if (est2)
        begin
            state      <= ovenPkg::stIdle;
            shiftDigit <= 1'b0;
            loadRecipe <= 1'b0;
            clearTime  <= 1'b0;
            countDown  <= 1'b0;
            motor      <= 1'b0;
            heater     <= 1'b0;
            doneCount  <= '0;
            beepCount  <= '0;
        end
        else
        begin
            state      <= stateNext;
            shiftDigit <= shiftNext;
            loadRecipe <= loadNext;
            clearTime  <= clearNext;
            countDown  <= countNext;
            motor      <= (stateNext == ovenPkg::stCooking);
            heater     <= (stateNext == ovenPkg::stCooking);
            if (state != ovenPkg::stDone)
                doneCount <= '0;
            else if (secTick)
                doneCount <= doneCount + 4'd1;
            if (keyAccepted)
                beepCount <= 3'(`BEEP_CYCLES);
            else if (beepCount != '0)
                beepCount <= beepCount - 3'd1;
        end
    end

    always_ff @(posedge r)
    begin
        newDigit  <= digitValue;
        recipeSel <= recipeIndex;
    end

    assign light  = door | motor;
    assign buzzer = (beepCount != '0) | (state == ovenPkg::stDone);

endmodule

// ==== logic/clockCounter.sv ====
`timescale 1ns/1ps
`include "oven_defs.svh"

module clockCounter
(
    input  logic                r,
    input  logic                est2,
    input  logic                secTick,
    output ovenPkg::bcdDigit    hourTens,
    output ovenPkg::bcdDigit    hourOnes,
    output ovenPkg::bcdDigit    minuteTens,
    output ovenPkg::bcdDigit    minuteOnes
);

    logic [5:0] secCount;
    logic       minuteStep;
    logic       lastHour;

    assign minuteStep = secTick && secCount == 6'(`SECONDS_PER_MINUTE - 1);
    assign lastHour   = hourTens == 4'(`HOUR_LIMIT / 10) &&
                        hourOnes == 4'(`HOUR_LIMIT % 10);

    always_ff @(posedge r or posedge est2)
    begin
        if (est2)
        begin
            secCount   <= '0;
            hourTens   <= '0;
            hourOnes   <= '0;
            minuteTens <= '0;
            minuteOnes <= '0;
        end
        else
        begin
            if (minuteStep)
                secCount <= '0;
            else if (secTick)
                secCount <= secCount + 6'd1;

            if (minuteStep)
            begin
                // Each digit rolls over only when all lower digits do
                if (minuteOnes != 4'd9)
                    minuteOnes <= minuteOnes + 4'd1;
                else
                begin
                    minuteOnes <= '0;
                    if (minuteTens != 4'd5)
                        minuteTens <= minuteTens + 4'd1;
                    else
                    begin
                        minuteTens <= '0;
                        if (lastHour)
                        begin
                            hourTens <= '0;
                            hourOnes <= '0;
                        end
                        else if (hourOnes == 4'd9)
                        begin
                            hourOnes <= '0;
                            hourTens <= hourTens + 4'd1;
                        end
                        else
                            hourOnes <= hourOnes + 4'd1;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/cookTimer.sv ====
`timescale 1ns/1ps
`include "oven_defs.svh"

module cookTimer
(
    input  logic                                    r,
    input  logic                                    est2,
    input  logic                                    shiftDigit,
    input  ovenPkg::bcdDigit                        newDigit,
    input  logic                                    loadRecipe,
    input  logic [1:0]                              recipeSel,
    input  logic                                    clearTime,
    input  logic                                    countDown,
    output ovenPkg::bcdDigit [`OVEN_DIGITS-1:0]     timeDigits,
    output logic                                    timeZero
);

    ovenPkg::bcdDigit [`OVEN_DIGITS-1:0] decDigits;
    ovenPkg::bcdDigit                    presetMinutes;
    logic                                borrow;

    assign timeZero      = (timeDigits == '0);
    assign presetMinutes = 4'({2'b00, recipeSel}) + 4'(`RECIPE_MINUTES_BASE);

    // The four digits form one decimal number, so a zero digit borrows as 9
    always_comb
    begin
        borrow = 1'b1;
        for (int i = 0; i < `OVEN_DIGITS; i++)
        begin
            if (!borrow)
                decDigits[i] = timeDigits[i];
            else if (timeDigits[i] == 4'd0)
                decDigits[i] = 4'd9;
            else
            begin
                decDigits[i] = timeDigits[i] - 4'd1;
                borrow       = 1'b0;
            end
        end
    end

    always_ff @(posedge r or posedge est2)
    begin
        if (est2)
            timeDigits <= '0;
        else if (loadRecipe)
        begin
            // Presets are whole minutes in MM:SS form
            timeDigits    <= '0;
            timeDigits[2] <= presetMinutes;
        end
        else if (shiftDigit)
        begin
            if (clearTime)
                timeDigits <= {12'd0, newDigit};
            else
                timeDigits <= {timeDigits[`OVEN_DIGITS-2:0], newDigit};
        end
        else if (clearTime)
            timeDigits <= '0;
        else if (countDown && !timeZero)
            timeDigits <= decDigits;
    end

endmodule

// ==== logic/displaySelect.sv ====
`timescale 1ns/1ps

module displaySelect
(
    input  logic                        r,
    input  logic                        est2,
    input  ovenPkg::ovenState           state,
    input  logic                        secTick,
    input  ovenPkg::bcdDigit            hourTens,
    input  ovenPkg::bcdDigit            hourOnes,
    input  ovenPkg::bcdDigit            minuteTens,
    input  ovenPkg::bcdDigit            minuteOnes,
    input  ovenPkg::bcdDigit [3:0]      timeDigits,
    output ovenPkg::bcdDigit            digit3,
    output ovenPkg::bcdDigit            digit2,
    output ovenPkg::bcdDigit            digit1,
    output ovenPkg::bcdDigit            digit0,
    output logic [3:0]                  digitEnable
);

    logic showClock;

    assign showClock = (state == ovenPkg::stIdle);

    always_ff @(posedge r or posedge est2)
    begin
        if (est2)
        begin
            digit3      <= '0;
            digit2      <= '0;
            digit1      <= '0;
            digit0      <= '0;
            digitEnable <= 4'hF;
        end
        else
        begin
            digit3 <= showClock ? hourTens   : timeDigits[3];
            digit2 <= showClock ? hourOnes   : timeDigits[2];
            digit1 <= showClock ? minuteTens : timeDigits[1];
            digit0 <= showClock ? minuteOnes : timeDigits[0];
            // Whole display blinks once per tick while the food is ready
            if (state != ovenPkg::stDone)
                digitEnable <= 4'hF;
            else if (secTick)
                digitEnable <= ~digitEnable;
        end
    end

endmodule

// ==== logic/microwaveTop.sv ====
`timescale 1ns/1ps

module microwaveTop
(
    input  logic                r,
    input  logic                est2,
    input  logic [9:0]          numKey,
    input  logic                startKey,
    input  logic                cancelKey,
    input  logic [3:0]          recipeKey,
    input  logic                door,
    input  logic                secTick,
    output ovenPkg::bcdDigit    digit3,
    output ovenPkg::bcdDigit    digit2,
    output ovenPkg::bcdDigit    digit1,
    output ovenPkg::bcdDigit    digit0,
    output logic [3:0]          digitEnable,
    output logic                light,
    output logic                motor,
    output logic                heater,
    output logic                buzzer
);

    logic                   digitPress;
    ovenPkg::bcdDigit       digitValue;
    logic                   startPress;
    logic                   cancelPress;
    logic                   recipePress;
    logic [1:0]             recipeIndex;
    ovenPkg::ovenState      state;
    logic                   shiftDigit;
    ovenPkg::bcdDigit       newDigit;
    logic                   loadRecipe;
    logic [1:0]             recipeSel;
    logic                   clearTime;
    logic                   countDown;
    logic                   timeZero;
    ovenPkg::bcdDigit [3:0] timeDigits;
    ovenPkg::bcdDigit       hourTens;
    ovenPkg::bcdDigit       hourOnes;
    ovenPkg::bcdDigit       minuteTens;
    ovenPkg::bcdDigit       minuteOnes;

    keyInput keyInputInst
    (
        .r(r), .est2(est2), .numKey(numKey), .startKey(startKey),
        .cancelKey(cancelKey), .recipeKey(recipeKey),
        .digitPress(digitPress), .digitValue(digitValue), .startPress(startPress),
        .cancelPress(cancelPress), .recipePress(recipePress), .recipeIndex(recipeIndex)
    );

    ovenCtrl ovenCtrlInst
    (
        .r(r), .est2(est2), .digitPress(digitPress), .digitValue(digitValue),
        .startPress(startPress), .cancelPress(cancelPress), .recipePress(recipePress),
        .recipeIndex(recipeIndex), .door(door), .secTick(secTick), .timeZero(timeZero),
        .state(state), .shiftDigit(shiftDigit), .newDigit(newDigit),
        .loadRecipe(loadRecipe), .recipeSel(recipeSel), .clearTime(clearTime),
        .countDown(countDown), .motor(motor), .heater(heater), .light(light),
        .buzzer(buzzer)
    );

    clockCounter clockCounterInst
    (
        .r(r), .est2(est2), .secTick(secTick),
        .hourTens(hourTens), .hourOnes(hourOnes),
        .minuteTens(minuteTens), .minuteOnes(minuteOnes)
    );

    cookTimer cookTimerInst
    (
        .r(r), .est2(est2), .shiftDigit(shiftDigit), .newDigit(newDigit),
        .loadRecipe(loadRecipe), .recipeSel(recipeSel), .clearTime(clearTime),
        .countDown(countDown), .timeDigits(timeDigits), .timeZero(timeZero)
    );

    displaySelect displaySelectInst
    (
        .r(r), .est2(est2), .state(state), .secTick(secTick),
        .hourTens(hourTens), .hourOnes(hourOnes),
        .minuteTens(minuteTens), .minuteOnes(minuteOnes), .timeDigits(timeDigits),
        .digit3(digit3), .digit2(digit2), .digit1(digit1), .digit0(digit0),
        .digitEnable(digitEnable)
    );

endmodule

// ==== verif/clockGen.sv ====
`timescale 1ns/1ps

module clockGen
(
    output logic r
);

    localparam int HalfPeriod = 5;

    // Free running 10 ns clock
    initial
    begin
        r = 1'b0;
        forever #HalfPeriod r = ~r;
    end

endmodule

// ==== verif/oven_assertions.sv ====
`timescale 1ns/1ps

module ovenAssertions
(
    input  logic    r,
    input  logic    est2,
    input  logic    door,
    input  logic    motor,
    input  logic    startPress,
    input  logic    cancelPress,
    input  logic    timeZero
);

    // The controller gets one cycle to react to the door, then the motor must stay off
    doorStopsMotor: assert property (@(posedge r) disable iff (est2)
        door && $past(door) |-> !motor)
        else $error("motor running with the door open");

    // Cooking only begins on a start with the door shut and time left on the timer
    motorNeedsStart: assert property (@(posedge r) disable iff (est2)
        $rose(motor) |-> $past(startPress && !door && !timeZero))
        else $error("motor started without an accepted start key");

    // Cancel pauses cooking on the next cycle
    cancelStopsMotor: assert property (@(posedge r) disable iff (est2)
        motor && cancelPress |=> !motor)
        else $error("motor still running after cancel");

endmodule

bind ovenCtrl ovenAssertions ovenAssertionsInst
(
    .r(r), .est2(est2), .door(door), .motor(motor), .startPress(startPress),
    .cancelPress(cancelPress), .timeZero(timeZero)
);

// ==== verif/microwaveTb.sv ====
`timescale 1ns/1ps
`include "oven_defs.svh"

module microwaveTb;

    localparam int ScriptDepth = 256;
    localparam int ResetCycles = 16;

    // Script commands sit in the top byte of each word
    localparam logic [7:0] CmdEnd     = 8'h00;
    localparam logic [7:0] CmdKey     = 8'h01;
    localparam logic [7:0] CmdStart   = 8'h02;
    localparam logic [7:0] CmdCancel  = 8'h03;
    localparam logic [7:0] CmdRecipe  = 8'h04;
    localparam logic [7:0] CmdDoor    = 8'h05;
    localparam logic [7:0] CmdTicks   = 8'h06;
    localparam logic [7:0] CmdWait    = 8'h07;
    localparam logic [7:0] CmdDigits  = 8'h10;
    localparam logic [7:0] CmdEnable  = 8'h11;
    localparam logic [7:0] CmdMotor   = 8'h12;
    localparam logic [7:0] CmdBuzzer  = 8'h13;
    localparam logic [7:0] CmdLight   = 8'h14;

    logic                       r;
    logic                       est2;
    logic [`KEY_COUNT-1:0]      numKey;
    logic                       startKey;
    logic                       cancelKey;
    logic [`RECIPE_COUNT-1:0]   recipeKey;
    logic                       door;
    logic                       secTick;
    ovenPkg::bcdDigit           digit3;
    ovenPkg::bcdDigit           digit2;
    ovenPkg::bcdDigit           digit1;
    ovenPkg::bcdDigit           digit0;
    logic [3:0]                 digitEnable;
    logic                       light;
    logic                       motor;
    logic                       heater;
    logic                       buzzer;

    logic [31:0] script [ScriptDepth];
    int          errorCount;
    int          checkCount;
    int          cycleCount;
    int          cycleLimit = 0;

    clockGen clockGenInst (.r(r));

    microwaveTop dut_i
    (
        .r(r), .est2(est2), .numKey(numKey), .startKey(startKey), .cancelKey(cancelKey),
        .recipeKey(recipeKey), .door(door), .secTick(secTick),
        .digit3(digit3), .digit2(digit2), .digit1(digit1), .digit0(digit0),
        .digitEnable(digitEnable), .light(light), .motor(motor), .heater(heater),
        .buzzer(buzzer)
    );

    task automatic compareDigit(input string name, input ovenPkg::bcdDigit actual,
                                input ovenPkg::bcdDigit expected);
        checkCount = checkCount + 1;
        if (actual !== expected)
        begin
            errorCount = errorCount + 1;
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic compareEnable(input string name, input logic [3:0] actual,
                                 input logic [3:0] expected);
        checkCount = checkCount + 1;
        if (actual !== expected)
        begin
            errorCount = errorCount + 1;
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic compareBit(input string name, input logic actual, input logic expected);
        checkCount = checkCount + 1;
        if (actual !== expected)
        begin
            errorCount = errorCount + 1;
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    // The last beep runs out first, then the button is held for two cycles and released
    task automatic pressButton(input logic [7:0] code, input logic [3:0] which);
        repeat (`BEEP_CYCLES) @(negedge r);
        case (code)
            CmdKey:    numKey = 10'd1 << which;
            CmdStart:  startKey = 1'b1;
            CmdCancel: cancelKey = 1'b1;
            default:   recipeKey = 4'd1 << which[1:0];
        endcase
        repeat (2) @(negedge r);
        numKey    = '0;
        startKey  = 1'b0;
        cancelKey = 1'b0;
        recipeKey = '0;
    endtask

    // Each tick is high for one cycle and low for the next
    task automatic giveTicks(input logic [23:0] count);
        for (int i = 0; i < int'(count); i++)
        begin
            secTick = 1'b1;
            @(negedge r);
            secTick = 1'b0;
            @(negedge r);
        end
    endtask

    function automatic int scriptCycles();
        int          total;
        int          idx;
        logic [7:0]  code;
        logic [23:0] arg;
        total = 0;
        idx   = 0;
        code  = 8'hff;
        while (idx < ScriptDepth && code != CmdEnd)
        begin
            code = script[idx][31:24];
            arg  = script[idx][23:0];
            case (code)
                CmdKey, CmdStart, CmdCancel, CmdRecipe: total = total + 2 + `BEEP_CYCLES;
                CmdTicks: total = total + 2 * int'(arg);
                CmdWait:  total = total + int'(arg);
                default:  ;
            endcase
            idx = idx + 1;
        end
        return total;
    endfunction

    initial
    begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit)
        begin
            @(posedge r);
            cycleCount = cycleCount + 1;
        end
        $display("Timeout: the script did not finish within %0d cycles", cycleLimit);
        $display("test failed");
        $finish;
    end

    initial
    begin
        logic [7:0]  code;
        logic [23:0] arg;
        int          pc;
        bit          running;
        errorCount = 0;
        checkCount = 0;
        est2       = 1'b1;
        numKey     = '0;
        startKey   = 1'b0;
        cancelKey  = 1'b0;
        recipeKey  = '0;
        door       = 1'b0;
        secTick    = 1'b0;
        $readmemh("verif/oven_input.txt", script);
        cycleLimit = 2 * (scriptCycles() + ResetCycles) + 2;
        repeat (ResetCycles) @(posedge r);
        @(negedge r);
        est2    = 1'b0;
        pc      = 0;
        running = 1'b1;
        while (running && pc < ScriptDepth)
        begin
            code = script[pc][31:24];
            arg  = script[pc][23:0];
            pc   = pc + 1;
            case (code)
                CmdEnd: running = 1'b0;
                CmdKey, CmdStart, CmdCancel, CmdRecipe: pressButton(code, arg[3:0]);
                CmdDoor:  door = arg[0];
                CmdTicks: giveTicks(arg);
                CmdWait:  repeat (int'(arg)) @(negedge r);
                CmdDigits:
                begin
                    compareDigit("digit3", digit3, arg[15:12]);
                    compareDigit("digit2", digit2, arg[11:8]);
                    compareDigit("digit1", digit1, arg[7:4]);
                    compareDigit("digit0", digit0, arg[3:0]);
                end
                CmdEnable: compareEnable("digitEnable", digitEnable, arg[3:0]);
                CmdMotor:
                begin
                    compareBit("motor", motor, arg[0]);
                    compareBit("heater", heater, arg[0]);
                end
                CmdBuzzer: compareBit("buzzer", buzzer, arg[0]);
                CmdLight:  compareBit("light", light, arg[0]);
                default:
                begin
                    errorCount = errorCount + 1;
                    $display("Script entry %0d holds an unknown command %h", pc - 1, code);
                    running = 1'b0;
                end
            endcase
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== verif/oven_input.txt ====
// Each word: command byte then a 24-bit argument, all hex
// 01 key 02 start 03 cancel 04 recipe 05 door 06 ticks 07 wait 10 digits 11 enable 12 motor 13 buzzer 14 light 00 end
07000006 // settle after reset
10000000 // clock shows 00:00
1100000f
12000000
13000000
14000000
0600003c // one minute of ticks
07000006
10000001
06015108 // run on to 23:59
07000006
10002359
0600003c // wrap to 00:00
07000006
10000000
01000001 // key 1 starts an entry
13000001
07000006
13000000
01000002
13000001
01000005
13000001
07000006
10000125
03000000 // cancel back to the clock
07000006
10000000
0600002d // 45 idle ticks
04000001 // recipe index 1 loads 0200
07000006
10000200
02000000 // start with door closed
07000006
12000001
14000001
0600000c // 12 ticks
07000006
10000188
05000001 // door opens while cooking
07000006
12000000
14000001
10000188
06000003 // ticks with door open do not count
07000006
10000188
05000000 // close door and resume
02000000
07000006
12000001
06000008
07000006
10000180
03000000 // cancel pauses
07000006
12000000
10000180
03000000 // second cancel clears, clock at 00:01
07000006
10000001
01000003 // key 3 then start
02000000
06000003 // count reaches zero
07000006
13000001 // done phase
12000000
1100000f
10000000
06000001
07000006
11000000
13000001
06000001
07000006
1100000f
06000001 // third done tick returns to idle
07000006
10000001
1100000f
13000000
04000000 // recipe index 0 loads 0100
05000001 // door open, start ignored
02000000
07000006
12000000
14000001
10000100
00000000 // end of script

// ==== flist.f ====
+incdir+logic
logic/ovenPkg.sv
logic/keyInput.sv
logic/ovenCtrl.sv
logic/clockCounter.sv
logic/cookTimer.sv
logic/displaySelect.sv
logic/microwaveTop.sv
verif/clockGen.sv
verif/oven_assertions.sv
verif/microwaveTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
verilator --binary --timing --assert -f flist.f --top-module microwaveTb -Mdir obj_dir \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/VmicrowaveTb > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
